//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := vfalu_tb
FILELIST  := vfalu.f
PASS_MSG  := All checks passed

OBJ_DIR := obj_dir
SRCS    := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- fp16_cmp_lane.sv
// lane_idx must stay below vfalu_lanes and a disabled lane passes its src0 slice through
`timescale 1ns/1ps

module fp16_cmp_lane
  import fp16_pkg::*;
  import vfalu_ctrl_pkg::*;
#(
  parameter int lane_idx = 0
)
(
  input  logic     ex1_pipe_clk,
  input  logic     cpurst_b,
  vfalu_ex2_if.ex2 ex2,
  output fp16_t    lane_result,
  output logic     lane_cmp,
  output logic     lane_nv
);

  localparam int lane_lo = lane_idx * fp16_w;

  fp16_t                 src_a;
  fp16_t                 src_b;
  logic                  a_sign;
  logic                  b_sign;
  logic [fp16_w-2:0]     a_mag;
  logic [fp16_w-2:0]     b_mag;
  logic [fp16_exp_w-1:0] a_exp;
  logic [fp16_exp_w-1:0] b_exp;
  logic [fp16_man_w-1:0] a_man;
  logic [fp16_man_w-1:0] b_man;
  logic                  a_qnan;
  logic                  a_snan;
  logic                  a_zero;
  logic                  b_qnan;
  logic                  b_snan;
  logic                  b_zero;
  logic                  any_nan;
  logic                  any_snan;
  logic                  a_eq_b;
  logic                  a_lt_b;
  logic                  a_lt_b_mm;
  logic                  cmp_bit;
  logic                  cmp_nv;
  fp16_t                 min_val;
  fp16_t                 max_val;
  fp16_t                 ex2_result;
  logic                  ex2_cmp;
  logic                  ex2_nv;

  // Lane slice of each operand
  assign src_a = ex2.ex2_src0[lane_lo +: fp16_w];
  assign src_b = ex2.ex2_src1[lane_lo +: fp16_w];

  assign a_sign = src_a[fp16_w-1];
  assign b_sign = src_b[fp16_w-1];
  assign a_mag  = src_a[fp16_w-2:0];
  assign b_mag  = src_b[fp16_w-2:0];
  assign a_exp  = src_a[fp16_man_w +: fp16_exp_w];
  assign b_exp  = src_b[fp16_man_w +: fp16_exp_w];
  assign a_man  = src_a[fp16_man_w-1:0];
  assign b_man  = src_b[fp16_man_w-1:0];

  // Quiet NaN has the top mantissa bit set
  assign a_qnan = (&a_exp) && a_man[fp16_man_w-1];
  assign a_snan = (&a_exp) && !a_man[fp16_man_w-1] && (|a_man);
  assign a_zero = ~|a_mag;
  assign b_qnan = (&b_exp) && b_man[fp16_man_w-1];
  assign b_snan = (&b_exp) && !b_man[fp16_man_w-1] && (|b_man);
  assign b_zero = ~|b_mag;

  assign any_snan = a_snan || b_snan;
  assign any_nan  = a_qnan || b_qnan || any_snan;

  // Ordering with -0 equal to +0
  assign a_eq_b = (src_a == src_b) || (a_zero && b_zero);

  always_comb
  begin
    if (a_sign != b_sign)
      a_lt_b = a_sign && !(a_zero && b_zero);
    else if (a_sign)
      a_lt_b = a_mag > b_mag;
    else
      a_lt_b = a_mag < b_mag;
  end

  // Min/max puts -0 below +0
  assign a_lt_b_mm = a_lt_b || (a_zero && b_zero && a_sign && !b_sign);

  // Unordered operands force feq/flt/fle low and fne high
  assign cmp_bit = (ex2.ex2_cmp_sel[sel_fne]  && (any_nan || !a_eq_b)) ||
                   (ex2.ex2_cmp_sel[sel_ford] && !any_nan) ||
                   (ex2.ex2_cmp_sel[sel_feq]  && !any_nan && a_eq_b) ||
                   (ex2.ex2_cmp_sel[sel_flt]  && !any_nan && a_lt_b) ||
                   (ex2.ex2_cmp_sel[sel_fle]  && !any_nan && (a_lt_b || a_eq_b));

  // Signaling compares flag any NaN and quiet ones only sNaN
  assign cmp_nv = (ex2.ex2_cmp_sel[sel_flt] || ex2.ex2_cmp_sel[sel_fle]) ? any_nan : any_snan;

  always_comb
  begin
    if ((a_qnan || a_snan) && (b_qnan || b_snan))
    begin
      min_val = fp16_qnan;
      max_val = fp16_qnan;
    end
    else if (a_qnan || a_snan)
    begin
      min_val = src_b;
      max_val = src_b;
    end
    else if (b_qnan || b_snan)
    begin
      min_val = src_a;
      max_val = src_a;
    end
    else
    begin
      min_val = a_lt_b_mm ? src_a : src_b;
      max_val = a_lt_b_mm ? src_b : src_a;
    end
  end

  // Lane result select
  always_comb
  begin
    ex2_result = src_a;
    ex2_cmp    = 1'b0;
    ex2_nv     = 1'b0;
    if (ex2.ex2_lane_en[lane_idx])
    begin
      if (ex2.ex2_op_cmp)
      begin
        ex2_cmp = cmp_bit;
        ex2_nv  = cmp_nv;
      end
      else if (ex2.ex2_op_minnm || ex2.ex2_op_maxnm)
      begin
        ex2_result = ex2.ex2_op_minnm ? min_val : max_val;
        ex2_nv     = any_snan;
      end
    end
  end

  // EX3 lane register
  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      lane_result <= '0;
      lane_cmp    <= 1'b0;
      lane_nv     <= 1'b0;
    end
    else if (ex2.ex2_vld && !ex2.pipe_hold)
    begin
      lane_result <= ex2_result;
      lane_cmp    <= ex2_cmp;
      lane_nv     <= ex2_nv;
    end
  end

endmodule

//--- fp16_pkg.sv
// Binary16 only with no subnormal special casing and flags kept in RISC-V order where only NV is raised
package fp16_pkg;

  // Field widths of one binary16 value
  localparam int fp16_exp_w = 5;
  localparam int fp16_man_w = 10;

  // Sign plus exponent plus mantissa
  localparam int fp16_w = 1 + fp16_exp_w + fp16_man_w;

  // One packed lane value
  typedef logic [fp16_w-1:0] fp16_t;

  // Canonical quiet NaN returned when both min/max operands are NaN
  localparam fp16_t fp16_qnan = 16'h7e00;

  // Exception flags NV DZ OF UF NX from bit 4 down to bit 0
  localparam int fflags_w = 5;

  typedef logic [fflags_w-1:0] fflags_t;

  // Invalid operation
  localparam int fflag_nv = 4;

endpackage

//--- vfalu.f
fp16_pkg.sv
vfalu_ctrl_pkg.sv
vfalu_ex2_if.sv
vfalu_ex1_decode.sv
fp16_cmp_lane.sv
vfalu_ex3_merge.sv
vfalu_top.sv
vfalu_tb.sv

//--- vfalu_ctrl_pkg.sv
// Function word is one-hot and the compare sub-op bits only count when the compare class is set
package vfalu_ctrl_pkg;

  // Four FP16 lanes packed into one 64-bit operand
  localparam int vfalu_lanes  = 4;
  localparam int vfalu_data_w = 64;

  typedef logic [vfalu_data_w-1:0] vfalu_data_t;
  typedef logic [vfalu_lanes-1:0]  lane_mask_t;

  // One-hot function word
  localparam int vfalu_func_w = 8;

  typedef logic [vfalu_func_w-1:0] vfalu_func_t;

  // Compare sub-op bits
  localparam int func_feq  = 0;
  localparam int func_flt  = 1;
  localparam int func_fle  = 2;
  localparam int func_ford = 3;
  localparam int func_fne  = 4;

  // Operation class bits
  localparam int func_cmp   = 5;
  localparam int func_minnm = 6;
  localparam int func_maxnm = 7;

  // Compare select, ordered fne ford feq flt fle from the top
  localparam int cmp_sel_w = 5;

  typedef logic [cmp_sel_w-1:0] cmp_sel_t;

  localparam int sel_fle  = 0;
  localparam int sel_flt  = 1;
  localparam int sel_feq  = 2;
  localparam int sel_ford = 3;
  localparam int sel_fne  = 4;

endpackage

//--- vfalu_ex1_decode.sv
// Expects a one-hot func with a single class bit and ignores in_vld while hold is high
`timescale 1ns/1ps

module vfalu_ex1_decode
  import vfalu_ctrl_pkg::*;
(
  input  logic        ex1_pipe_clk,
  input  logic        cpurst_b,
  input  logic        in_vld,
  input  vfalu_func_t func,
  input  lane_mask_t  lane_en,
  input  vfalu_data_t src0,
  input  vfalu_data_t src1,
  input  logic        hold,
  vfalu_ex2_if.ex1    ex2
);

  logic     ex1_pipedown;
  logic     ex1_op_cmp;
  logic     ex1_op_minnm;
  logic     ex1_op_maxnm;
  cmp_sel_t ex1_cmp_sel;

  // Whole pipe advances together
  assign ex1_pipedown = !hold;

  // Operation class
  assign ex1_op_cmp   = func[func_cmp];
  assign ex1_op_minnm = func[func_minnm];
  assign ex1_op_maxnm = func[func_maxnm];

  // Sub-op bits are qualified by the compare class
  assign ex1_cmp_sel[sel_fne]  = ex1_op_cmp && func[func_fne];
  assign ex1_cmp_sel[sel_ford] = ex1_op_cmp && func[func_ford];
  assign ex1_cmp_sel[sel_feq]  = ex1_op_cmp && func[func_feq];
  assign ex1_cmp_sel[sel_flt]  = ex1_op_cmp && func[func_flt];
  assign ex1_cmp_sel[sel_fle]  = ex1_op_cmp && func[func_fle];

  // Flop valid and controls into EX2
  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex2.ex2_vld      <= 1'b0;
      ex2.ex2_op_cmp   <= 1'b0;
      ex2.ex2_cmp_sel  <= '0;
      ex2.ex2_op_minnm <= 1'b0;
      ex2.ex2_op_maxnm <= 1'b0;
      ex2.ex2_lane_en  <= '0;
    end
    else if (ex1_pipedown)
    begin
      ex2.ex2_vld      <= in_vld;
      ex2.ex2_op_cmp   <= ex1_op_cmp;
      ex2.ex2_cmp_sel  <= ex1_cmp_sel;
      ex2.ex2_op_minnm <= ex1_op_minnm;
      ex2.ex2_op_maxnm <= ex1_op_maxnm;
      ex2.ex2_lane_en  <= lane_en;
    end
  end

  // Operand payload is loaded only for a real operation
  always_ff @(posedge ex1_pipe_clk)
  begin
    if (ex1_pipedown && in_vld)
    begin
      ex2.ex2_src0 <= src0;
      ex2.ex2_src1 <= src1;
    end
  end

  // Lanes and merge see the same hold
  assign ex2.pipe_hold = hold;

  // Accepted op lands in EX2 with one class and, for compares, one sub-op
  a_ex2_onehot: assert property (
    @(posedge ex1_pipe_clk) disable iff (!cpurst_b)
    (in_vld && !hold) |=>
      ex2.ex2_vld &&
      $onehot({ex2.ex2_op_cmp, ex2.ex2_op_minnm, ex2.ex2_op_maxnm}) &&
      (!ex2.ex2_op_cmp || $onehot(ex2.ex2_cmp_sel))
  ) else $error("EX2 holds an operation without a single class or sub-op");

endmodule

//--- vfalu_ex2_if.sv
// EX2 controls are only meaningful while ex2_vld is high and pipe_hold freezes every stage
`timescale 1ns/1ps

interface vfalu_ex2_if import vfalu_ctrl_pkg::*; ();

  // Stage control
  logic        ex2_vld;
  logic        pipe_hold;

  // Decoded operation
  logic        ex2_op_cmp;
  cmp_sel_t    ex2_cmp_sel;
  logic        ex2_op_minnm;
  logic        ex2_op_maxnm;

  // Lane mask and packed operands
  lane_mask_t  ex2_lane_en;
  vfalu_data_t ex2_src0;
  vfalu_data_t ex2_src1;

  // Decoder side
  modport ex1 (
    output ex2_vld, pipe_hold, ex2_op_cmp, ex2_cmp_sel, ex2_op_minnm, ex2_op_maxnm,
           ex2_lane_en, ex2_src0, ex2_src1
  );

  // Lane and merge side
  modport ex2 (
    input  ex2_vld, pipe_hold, ex2_op_cmp, ex2_cmp_sel, ex2_op_minnm, ex2_op_maxnm,
           ex2_lane_en, ex2_src0, ex2_src1
  );

endinterface

//--- vfalu_ex3_merge.sv
// Lane results sit in EX3 alongside the EX3 valid and result keeps its last value between ops
`timescale 1ns/1ps

module vfalu_ex3_merge
  import fp16_pkg::*;
  import vfalu_ctrl_pkg::*;
(
  input  logic                    ex1_pipe_clk,
  input  logic                    cpurst_b,
  vfalu_ex2_if.ex2                ex2,
  input  fp16_t [vfalu_lanes-1:0] lane_result,
  input  lane_mask_t              lane_cmp,
  input  lane_mask_t              lane_nv,
  output vfalu_data_t             result,
  output fflags_t                 fflags,
  output logic                    result_vld
);

  logic        ex3_pipedown;
  logic        ex3_vld;
  logic        ex3_op_cmp;
  vfalu_data_t ex3_result;
  fflags_t     ex3_fflags;

  assign ex3_pipedown = !ex2.pipe_hold;

  // EX3 copies of the stage controls
  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex3_vld    <= 1'b0;
      ex3_op_cmp <= 1'b0;
    end
    else if (ex3_pipedown)
    begin
      ex3_vld    <= ex2.ex2_vld;
      ex3_op_cmp <= ex2.ex2_op_cmp;
    end
  end

  // Compare bits in the low nibble or lane 0 lowest
  always_comb
  begin
    if (ex3_op_cmp)
      ex3_result = vfalu_data_t'(lane_cmp);
    else
      ex3_result = lane_result;
    ex3_fflags           = '0;
    ex3_fflags[fflag_nv] = |lane_nv;
  end

  // Output registers
  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      result_vld <= 1'b0;
      result     <= '0;
      fflags     <= '0;
    end
    else if (ex3_pipedown)
    begin
      result_vld <= ex3_vld;
      if (ex3_vld)
      begin
        result <= ex3_result;
        fflags <= ex3_fflags;
      end
    end
  end

  // Lanes raise no compare bit for a min/max op
  a_mm_no_cmp: assert property (
    @(posedge ex1_pipe_clk) disable iff (!cpurst_b)
    (ex3_vld && !ex3_op_cmp) |-> (lane_cmp == '0)
  ) else $error("Lane compare bits set on a min/max result");

endmodule

//--- vfalu_tb.sv
// Needs a simulator with timing support and checks only the rows of its own table
`timescale 1ns/1ps

module vfalu_tb
  import fp16_pkg::*;
  import vfalu_ctrl_pkg::*;
();

  localparam logic [31:0] lfsr_seed = 32'h676dc808;

  // One-hot function words
  localparam vfalu_func_t op_feq   = vfalu_func_t'((1 << func_cmp) | (1 << func_feq));
  localparam vfalu_func_t op_flt   = vfalu_func_t'((1 << func_cmp) | (1 << func_flt));
  localparam vfalu_func_t op_fle   = vfalu_func_t'((1 << func_cmp) | (1 << func_fle));
  localparam vfalu_func_t op_ford  = vfalu_func_t'((1 << func_cmp) | (1 << func_ford));
  localparam vfalu_func_t op_fne   = vfalu_func_t'((1 << func_cmp) | (1 << func_fne));
  localparam vfalu_func_t op_minnm = vfalu_func_t'(1 << func_minnm);
  localparam vfalu_func_t op_maxnm = vfalu_func_t'(1 << func_maxnm);

  // Operand sets with lane 3 on the left
  localparam vfalu_data_t ord_a = 64'h4000_8000_bc00_3c00;
  localparam vfalu_data_t ord_b = 64'h3c00_0000_3c00_3c00;
  localparam vfalu_data_t neg_a = 64'h0000_4200_bc00_c000;
  localparam vfalu_data_t neg_b = 64'h8000_4200_c000_bc00;
  localparam vfalu_data_t qn_a  = 64'h3c00_fe00_3c00_7e00;
  localparam vfalu_data_t qn_b  = 64'h4000_7e00_7e00_3c00;
  localparam vfalu_data_t sn_a  = 64'h3c00_3c00_3c00_7c01;
  localparam vfalu_data_t sn_b  = 64'h0000_3c00_7d00_3c00;
  localparam vfalu_data_t mm_a  = 64'h7e00_c000_8000_3c00;
  localparam vfalu_data_t mm_b  = 64'h4200_bc00_0000_bc00;
  localparam vfalu_data_t mmn_a = 64'h3800_7c01_7e55_0000;
  localparam vfalu_data_t mmn_b = 64'h7c01_c200_fe00_8000;

  typedef struct packed {
    vfalu_func_t func;
    lane_mask_t  en;
    vfalu_data_t a;
    vfalu_data_t b;
    vfalu_data_t exp_res;
    fflags_t     exp_flags;
  } row_t;

  logic        ex1_pipe_clk;
  logic        cpurst_b;
  logic        in_vld;
  vfalu_func_t func;
  lane_mask_t  lane_en;
  vfalu_data_t src0;
  vfalu_data_t src1;
  logic        hold;
  vfalu_data_t result;
  fflags_t     fflags;
  logic        result_vld;

  row_t        rows[$];
  int          exp_q[$];
  int          cur_idx;
  int          issue_idx;
  int          mon_idx;
  int          errs_before;
  int          errors;
  int          n_pass;
  int          n_fail;
  int          done_cnt;
  int          limit;
  int          cycles;
  logic [31:0] lfsr;
  logic        hold_bit;
  logic        out_new = 1'b0;
  logic        reset_checked = 1'b0;

  vfalu_top u_dut (
    .ex1_pipe_clk (ex1_pipe_clk),
    .cpurst_b     (cpurst_b),
    .in_vld       (in_vld),
    .func         (func),
    .lane_en      (lane_en),
    .src0         (src0),
    .src1         (src1),
    .hold         (hold),
    .result       (result),
    .fflags       (fflags),
    .result_vld   (result_vld)
  );

  initial
  begin
    ex1_pipe_clk = 1'b0;
    forever #50 ex1_pipe_clk = ~ex1_pipe_clk;
  end

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      lfsr_next = (state >> 1) ^ 32'h80200003;
    else
      lfsr_next = state >> 1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected)
    begin
      $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  task automatic add_row(input vfalu_func_t f, input lane_mask_t en, input vfalu_data_t a,
                         input vfalu_data_t b, input vfalu_data_t res, input fflags_t fl);
    row_t r;
    r = {f, en, a, b, res, fl};
    rows.push_back(r);
  endtask

  task automatic load_table();
    // Ordinary values with -0 against +0 in lane 2
    add_row(op_feq,   4'hf, ord_a, ord_b, 64'h5, 5'h00);
    add_row(op_flt,   4'hf, ord_a, ord_b, 64'h2, 5'h00);
    add_row(op_fle,   4'hf, ord_a, ord_b, 64'h7, 5'h00);
    add_row(op_fne,   4'hf, ord_a, ord_b, 64'ha, 5'h00);
    add_row(op_ford,  4'hf, ord_a, ord_b, 64'hf, 5'h00);
    add_row(op_flt,   4'hf, neg_a, neg_b, 64'h1, 5'h00);
    add_row(op_fle,   4'hf, neg_a, neg_b, 64'hd, 5'h00);
    add_row(op_feq,   4'hf, neg_a, neg_b, 64'hc, 5'h00);
    // Quiet NaNs
    add_row(op_feq,   4'hf, qn_a,  qn_b,  64'h0, 5'h00);
    add_row(op_flt,   4'hf, qn_a,  qn_b,  64'h8, 5'h10);
    add_row(op_fle,   4'hf, qn_a,  qn_b,  64'h8, 5'h10);
    add_row(op_fne,   4'hf, qn_a,  qn_b,  64'hf, 5'h00);
    add_row(op_ford,  4'hf, qn_a,  qn_b,  64'h8, 5'h00);
    // Signaling NaNs
    add_row(op_feq,   4'hf, sn_a,  sn_b,  64'h4, 5'h10);
    add_row(op_flt,   4'hf, sn_a,  sn_b,  64'h0, 5'h10);
    add_row(op_fle,   4'hf, sn_a,  sn_b,  64'h4, 5'h10);
    add_row(op_fne,   4'hf, sn_a,  sn_b,  64'hb, 5'h10);
    add_row(op_ford,  4'hf, sn_a,  sn_b,  64'hc, 5'h10);
    // Min and max
    add_row(op_minnm, 4'hf, mm_a,  mm_b,  64'h4200_c000_8000_bc00, 5'h00);
    add_row(op_maxnm, 4'hf, mm_a,  mm_b,  64'h4200_bc00_0000_3c00, 5'h00);
    add_row(op_minnm, 4'hf, mmn_a, mmn_b, 64'h3800_c200_7e00_8000, 5'h10);
    add_row(op_maxnm, 4'hf, mmn_a, mmn_b, 64'h3800_c200_7e00_0000, 5'h10);
    // Disabled lanes hide their NaNs and their true compare bits
    add_row(op_fne,   4'hc, sn_a,  sn_b,  64'h8, 5'h00);
    add_row(op_flt,   4'h8, qn_a,  qn_b,  64'h8, 5'h00);
    add_row(op_maxnm, 4'h3, mmn_a, mmn_b, 64'h3800_7c01_7e00_0000, 5'h00);
    add_row(op_minnm, 4'h0, mm_a,  mm_b,  64'h7e00_c000_8000_3c00, 5'h00);
  endtask

  // Stimulus
  initial
  begin
    cpurst_b <= 1'b0;
    in_vld   <= 1'b0;
    func     <= '0;
    lane_en  <= '0;
    src0     <= '0;
    src1     <= '0;
    hold     <= 1'b0;
    cur_idx  <= 0;
    load_table();
    limit = 4 * rows.size() + 50;
    lfsr  = lfsr_seed;
    repeat (2) @(posedge ex1_pipe_clk);
    cpurst_b <= 1'b1;
    repeat (2) @(posedge ex1_pipe_clk);
    issue_idx = 0;
    while (issue_idx < rows.size())
    begin
      @(posedge ex1_pipe_clk);
      hold_bit = lfsr[0];
      lfsr     = lfsr_next(lfsr);
      in_vld  <= 1'b1;
      cur_idx <= issue_idx;
      func    <= rows[issue_idx].func;
      lane_en <= rows[issue_idx].en;
      src0    <= rows[issue_idx].a;
      src1    <= rows[issue_idx].b;
      hold    <= hold_bit;
      // Held entry is offered again
      if (!hold_bit)
        issue_idx++;
    end
    @(posedge ex1_pipe_clk);
    in_vld <= 1'b0;
    hold   <= 1'b0;
    wait (done_cnt == rows.size());
    // Room for a stray extra result
    repeat (4) @(posedge ex1_pipe_clk);
    $display("Totals: %0d entries, %0d ok, %0d failed, %0d errors",
             rows.size(), n_pass, n_fail, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // Outputs only move on an edge without hold
  always @(posedge ex1_pipe_clk)
  begin
    if (cpurst_b && !reset_checked)
    begin
      errs_before = errors;
      check_value("result_vld", 64'(result_vld), 64'h0);
      check_value("result", result, 64'h0);
      check_value("fflags", 64'(fflags), 64'h0);
      $display("Reset state: %s", (errors == errs_before) ? "ok" : "FAILED");
      reset_checked = 1'b1;
    end
    if (out_new && result_vld)
    begin
      if (exp_q.size() == 0)
      begin
        $display("A result came out with no operation in flight");
        errors++;
      end
      else
      begin
        mon_idx     = exp_q.pop_front();
        errs_before = errors;
        check_value("result", result, rows[mon_idx].exp_res);
        check_value("fflags", 64'(fflags), 64'(rows[mon_idx].exp_flags));
        if (errors == errs_before)
          n_pass++;
        else
          n_fail++;
        $display("Entry %0d func 0x%h lanes 0x%h: %s", mon_idx, rows[mon_idx].func,
                 rows[mon_idx].en, (errors == errs_before) ? "ok" : "FAILED");
        done_cnt++;
      end
    end
    if (cpurst_b && in_vld && !hold)
      exp_q.push_back(cur_idx);
    out_new = cpurst_b && !hold;
  end

  // Cycle limit
  initial
  begin
    cycles = 0;
    @(posedge ex1_pipe_clk);
    while (cycles < limit)
    begin
      @(posedge ex1_pipe_clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with only %0d of %0d entries finished",
             cycles, done_cnt, rows.size());
    $display("Checks failed");
    $finish;
  end

endmodule

//--- vfalu_top.sv
// Three register stages with no ready so hold is the only backpressure
`timescale 1ns/1ps

module vfalu_top
  import fp16_pkg::*;
  import vfalu_ctrl_pkg::*;
(
  input  logic        ex1_pipe_clk,
  input  logic        cpurst_b,
  input  logic        in_vld,
  input  vfalu_func_t func,
  input  lane_mask_t  lane_en,
  input  vfalu_data_t src0,
  input  vfalu_data_t src1,
  input  logic        hold,
  output vfalu_data_t result,
  output fflags_t     fflags,
  output logic        result_vld
);

  fp16_t [vfalu_lanes-1:0] lane_result;
  lane_mask_t              lane_cmp;
  lane_mask_t              lane_nv;

  vfalu_ex2_if ex2_if ();

  vfalu_ex1_decode x_ex1_decode (
    .ex1_pipe_clk (ex1_pipe_clk),
    .cpurst_b     (cpurst_b),
    .in_vld       (in_vld),
    .func         (func),
    .lane_en      (lane_en),
    .src0         (src0),
    .src1         (src1),
    .hold         (hold),
    .ex2          (ex2_if.ex1)
  );

  // One lane per FP16 slice
  for (genvar i = 0; i < vfalu_lanes; i++)
  begin : g_lane
    fp16_cmp_lane #(
      .lane_idx (i)
    ) x_lane (
      .ex1_pipe_clk (ex1_pipe_clk),
      .cpurst_b     (cpurst_b),
      .ex2          (ex2_if.ex2),
      .lane_result  (lane_result[i]),
      .lane_cmp     (lane_cmp[i]),
      .lane_nv      (lane_nv[i])
    );
  end

  vfalu_ex3_merge x_ex3_merge (
    .ex1_pipe_clk (ex1_pipe_clk),
    .cpurst_b     (cpurst_b),
    .ex2          (ex2_if.ex2),
    .lane_result  (lane_result),
    .lane_cmp     (lane_cmp),
    .lane_nv      (lane_nv),
    .result       (result),
    .fflags       (fflags),
    .result_vld   (result_vld)
  );

endmodule
